//--- Makefile
# Verilator build and run of the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= mem_subsys_tb
FILELIST  ?= mem_subsys_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= TEST PASSED

SOURCES := $(wildcard source/*.sv) $(wildcard testbench/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_TEXT"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "result: pass"; \
	else \
		echo "result: fail, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- mem_subsys_top.f
source/mem_subsys_pkg.sv
source/rst_stretch.sv
source/req_fifo.sv
source/mem_bridge.sv
source/byte_mem.sv
source/mem_subsys_top.sv
testbench/mem_subsys_chk.sv
testbench/mem_subsys_scoreboard.sv
testbench/mem_subsys_tb.sv

//--- source/byte_mem.sv
`timescale 1ns/10ps

module byte_mem import mem_subsys_pkg::*; (
    input  logic  clk,

    input  logic  en,
    input  logic  we,
    input  strb_t be,
    input  addr_t addr,
    input  data_t wdata,
    output data_t rdata
);

    data_t mem [MEM_WORDS];

    // byte lanes written independently
    always_ff @(posedge clk) begin
        if (en && we) begin
            for (int k = 0; k < STRB_W; k++) begin
                if (be[k]) begin
                    mem[addr][8*k +: 8] <= wdata[8*k +: 8];
                end
            end
        end
    end

    // registered read, rdata holds between reads
    always_ff @(posedge clk) begin
        if (en && !we) begin
            rdata <= mem[addr];
        end
    end

endmodule

//--- source/mem_bridge.sv
`timescale 1ns/10ps

module mem_bridge import mem_subsys_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,

    input  logic     in_valid,
    output logic     in_ready,
    input  mem_req_t in_req,

    output logic     mem_en,
    output logic     mem_we,
    output strb_t    mem_be,
    output addr_t    mem_addr,
    output data_t    mem_wdata,
    input  data_t    mem_rdata,

    output logic     rsp_valid,
    input  logic     rsp_ready,
    output mem_rsp_t rsp
);

    bridge_state_t state;
    mem_req_t      req_q;
    mem_rsp_t      rsp_q;

    // second half of ACCESS, memory output is valid here
    logic access_wait;

    logic pop;
    logic capture;

    assign in_ready  = (state == IDLE);
    assign pop       = in_valid && in_ready;
    assign capture   = (state == ACCESS) && access_wait;

    assign rsp_valid = (state == RESPOND);
    assign rsp       = rsp_q;

    // memory is driven straight from the held request
    assign mem_en    = (state == ACCESS) && !access_wait;
    assign mem_we    = req_q.we;
    assign mem_be    = req_q.be;
    assign mem_addr  = req_q.addr;
    assign mem_wdata = req_q.wdata;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= IDLE;
            access_wait <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (pop) begin
                        state <= ACCESS;
                    end
                end
                ACCESS: begin
                    if (access_wait) begin
                        access_wait <= 1'b0;
                        state       <= RESPOND;
                    end else begin
                        access_wait <= 1'b1;
                    end
                end
                RESPOND: begin
                    // no new pop until the response leaves
                    if (rsp_ready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            req_q <= in_req;
        end
        if (capture) begin
            rsp_q.we    <= req_q.we;
            rsp_q.rdata <= req_q.we ? '0 : mem_rdata;
        end
    end

endmodule

//--- source/mem_subsys_pkg.sv
package mem_subsys_pkg;

    // memory geometry
    localparam int MEM_WORDS = 1024;
    localparam int ADDR_W    = 10;
    localparam int DATA_W    = 32;
    localparam int STRB_W    = 4;

    // request buffering
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    // cycles of internal reset after rst_n is released
    localparam int RST_HOLD  = 16;
    localparam int RST_CNT_W = $clog2(RST_HOLD + 1);

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    // bit k enables data bits 8k+7:8k
    typedef logic [STRB_W-1:0] strb_t;

    // 47 bits
    typedef struct packed {
        logic  we;
        strb_t be;
        addr_t addr;
        data_t wdata;
    } mem_req_t;

    // 33 bits, rdata is zero for a write
    typedef struct packed {
        logic  we;
        data_t rdata;
    } mem_rsp_t;

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        RESPOND
    } bridge_state_t;

endpackage

//--- source/mem_subsys_top.sv
`timescale 1ns/10ps

module mem_subsys_top import mem_subsys_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,

    // request port
    input  logic     req_valid,
    output logic     req_ready,
    input  mem_req_t req,

    // response port
    output logic     rsp_valid,
    input  logic     rsp_ready,
    output mem_rsp_t rsp
);

    logic     rst_int_n;

    logic     fifo_valid;
    logic     fifo_ready;
    mem_req_t fifo_req;

    logic     mem_en;
    logic     mem_we;
    strb_t    mem_be;
    addr_t    mem_addr;
    data_t    mem_wdata;
    data_t    mem_rdata;

    rst_stretch i_rst_stretch (
        .clk       (clk),
        .rst_n     (rst_n),
        .rst_int_n (rst_int_n)
    );

    req_fifo i_req_fifo (
        .clk       (clk),
        .rst_n     (rst_int_n),

        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in_req    (req),

        .out_valid (fifo_valid),
        .out_ready (fifo_ready),
        .out_req   (fifo_req)
    );

    mem_bridge i_mem_bridge (
        .clk       (clk),
        .rst_n     (rst_int_n),

        .in_valid  (fifo_valid),
        .in_ready  (fifo_ready),
        .in_req    (fifo_req),

        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_be    (mem_be),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),

        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

    // contents survive reset
    byte_mem i_byte_mem (
        .clk   (clk),

        .en    (mem_en),
        .we    (mem_we),
        .be    (mem_be),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

endmodule

//--- source/req_fifo.sv
`timescale 1ns/10ps

module req_fifo import mem_subsys_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,

    input  logic     in_valid,
    output logic     in_ready,
    input  mem_req_t in_req,

    output logic     out_valid,
    input  logic     out_ready,
    output mem_req_t out_req
);

    mem_req_t entries [FIFO_DEPTH];

    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;
    logic [FIFO_CNT_W-1:0] count_next;

    logic push;
    logic pop;

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    // head entry is presented as soon as it is stored
    assign out_valid = (count != '0);
    assign out_req   = entries[rd_ptr];

    always_comb begin
        count_next = count;
        case ({push, pop})
            2'b10:   count_next = count + 1'b1;
            2'b01:   count_next = count - 1'b1;
            default: count_next = count;
        endcase
    end

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            in_ready <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count_next;
            // ready drops only when all entries are held
            in_ready <= (count_next != FIFO_CNT_W'(FIFO_DEPTH));
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= in_req;
        end
    end

endmodule

//--- source/rst_stretch.sv
`timescale 1ns/10ps

module rst_stretch import mem_subsys_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    output logic rst_int_n
);

    logic [RST_CNT_W-1:0] count;

    // counter restarts on every assertion of rst_n
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count     <= '0;
            rst_int_n <= 1'b0;
        end else begin
            if (count == RST_CNT_W'(RST_HOLD)) begin
                // hold released, count stays parked
                rst_int_n <= 1'b1;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

//--- testbench/mem_subsys_chk.sv
`timescale 1ns/10ps

module mem_subsys_chk import mem_subsys_pkg::*; (
    input logic     clk,
    input logic     rst_int_n,
    input logic     req_valid,
    input logic     req_ready,
    input mem_req_t req,
    input logic     rsp_valid,
    input logic     rsp_ready,
    input mem_rsp_t rsp
);

    // number of failed assertions
    int fail_count = 0;

    // a stalled request keeps valid and payload until taken
    property req_held;
        @(posedge clk) disable iff (!rst_int_n)
            req_valid && !req_ready |=> req_valid && $stable(req);
    endproperty

    // same rule on the response side
    property rsp_held;
        @(posedge clk) disable iff (!rst_int_n)
            rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp);
    endproperty

    // both handshake outputs quiet once internal reset has been seen
    property quiet_in_reset;
        @(posedge clk)
            !rst_int_n && $past(!rst_int_n) |-> !req_ready && !rsp_valid;
    endproperty

    a_req_held: assert property (req_held)
        else begin
            $error("request payload changed while stalled");
            fail_count++;
        end
    a_rsp_held: assert property (rsp_held)
        else begin
            $error("response payload changed while stalled");
            fail_count++;
        end
    a_quiet_in_reset: assert property (quiet_in_reset)
        else begin
            $error("handshake output high during internal reset");
            fail_count++;
        end

endmodule

//--- testbench/mem_subsys_scoreboard.sv
`timescale 1ns/10ps

module mem_subsys_scoreboard import mem_subsys_pkg::*; (
    input  logic     clk,
    input  logic     req_valid,
    input  logic     req_ready,
    input  mem_req_t req,
    input  logic     rsp_valid,
    input  logic     rsp_ready,
    input  mem_rsp_t rsp,
    output int       err_count,
    output int       rsp_count,
    output int       pending
);

    data_t    ref_mem [MEM_WORDS];
    mem_rsp_t expected_q [$];

    int errs = 0;
    int seen = 0;
    int depth = 0;

    assign err_count = errs;
    assign rsp_count = seen;
    assign pending   = depth;

    // merges a write by byte mask, returns what the DUT should answer
    function automatic mem_rsp_t predict_rsp(input mem_req_t r, input data_t old_word,
                                             output data_t new_word);
        mem_rsp_t expect_rsp;
        data_t    mask;
        for (int k = 0; k < STRB_W; k++) begin
            mask[8*k +: 8] = {8{r.be[k]}};
        end
        expect_rsp.we    = r.we;
        expect_rsp.rdata = r.we ? '0 : old_word;
        new_word         = r.we ? ((old_word & ~mask) | (r.wdata & mask)) : old_word;
        return expect_rsp;
    endfunction

    // values settle by mid-cycle, so a handshake seen here completes on the next edge
    always @(negedge clk) begin : compare
        mem_rsp_t expect_rsp;
        data_t    merged;
        if (rsp_valid === 1'b1 && rsp_ready === 1'b1) begin
            seen++;
            if (expected_q.size() == 0) begin
                $display("response arrived with no request outstanding");
                errs++;
            end else begin
                expect_rsp = expected_q.pop_front();
                if (rsp.we !== expect_rsp.we) begin
                    $display("ERR rsp.we expected %h got %h", expect_rsp.we, rsp.we);
                    errs++;
                end
                if (rsp.rdata !== expect_rsp.rdata) begin
                    $display("ERR rsp.rdata expected %h got %h", expect_rsp.rdata, rsp.rdata);
                    errs++;
                end
            end
        end
        if (req_valid === 1'b1 && req_ready === 1'b1) begin
            expect_rsp = predict_rsp(req, ref_mem[req.addr], merged);
            ref_mem[req.addr] = merged;
            expected_q.push_back(expect_rsp);
        end
        depth = expected_q.size();
    end

endmodule

//--- testbench/mem_subsys_tb.sv
`timescale 1ns/10ps

module mem_subsys_tb
    import mem_subsys_pkg::*;
();

    localparam int WORDS_USED   = 8;
    localparam int BURST_LEN    = 16;
    localparam int BP_LIMIT     = 12;
    localparam int WAIT_CYCLES  = 200;
    localparam int IDLE_LATENCY = 3;
    localparam int NUM_TESTS    = 5;

    localparam int READY_LOW    = 0;
    localparam int READY_HIGH   = 1;
    localparam int READY_RANDOM = 2;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     req_valid;
    logic     req_ready;
    mem_req_t req;
    logic     rsp_valid;
    logic     rsp_ready = 1'b0;
    mem_rsp_t rsp;

    int       sb_errors;
    int       sb_responses;
    int       sb_pending;

    integer   seed = 26558;
    int       rsp_mode = READY_HIGH;
    int       tb_errors = 0;
    int       timeouts = 0;
    int       tests_failed = 0;
    int       sent = 0;
    int       err_mark;
    int       timeout_mark;
    addr_t    used_addr [WORDS_USED];

    always #10 clk = ~clk;

    mem_subsys_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

    mem_subsys_scoreboard i_scoreboard (
        .clk       (clk),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp),
        .err_count (sb_errors),
        .rsp_count (sb_responses),
        .pending   (sb_pending)
    );

    bind mem_subsys_top mem_subsys_chk i_chk (
        .clk       (clk),
        .rst_int_n (rst_int_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

    // scoreboard, testbench and assertion failures together
    function automatic int error_total();
        return sb_errors + tb_errors + i_dut.i_chk.fail_count;
    endfunction

    // response side ready, pattern chosen by the running test
    always @(posedge clk) begin
        #1;
        case (rsp_mode)
            READY_LOW:  rsp_ready = 1'b0;
            READY_HIGH: rsp_ready = 1'b1;
            default:    rsp_ready = (($random(seed) & 3) != 0);
        endcase
    end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    function automatic mem_req_t make_req(input logic we, input strb_t be, input addr_t addr,
                                          input data_t wdata);
        mem_req_t r;
        r.we    = we;
        r.be    = be;
        r.addr  = addr;
        r.wdata = wdata;
        return r;
    endfunction

    // read or write to a word that already holds known data
    function automatic mem_req_t random_req();
        int idx;
        idx = $random(seed) & (WORDS_USED - 1);
        return make_req(($random(seed) & 1) != 0, strb_t'($random(seed)), used_addr[idx],
                        data_t'($random(seed)));
    endfunction

    // returns one cycle after the request was taken
    task automatic send_req(input mem_req_t r);
        int waited;
        waited    = 0;
        req_valid = 1'b1;
        req       = r;
        while (req_ready !== 1'b1 && waited < WAIT_CYCLES) begin
            tick();
            waited++;
        end
        if (req_ready !== 1'b1) begin
            $display("timeout: request to address %h was never accepted", r.addr);
            timeouts++;
        end else begin
            tick();
            sent++;
        end
        req_valid = 1'b0;
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (sb_pending != 0 && waited < WAIT_CYCLES) begin
            tick();
            waited++;
        end
        if (sb_pending != 0) begin
            $display("timeout: %0d responses never arrived", sb_pending);
            timeouts++;
        end
    endtask

    task automatic check_reset_hold();
        int waited;
        for (int i = 0; i < 5; i++) begin
            tick();
            if (req_ready === 1'b1) begin
                $display("ERR req_ready expected %h got %h", 1'b0, req_ready);
                tb_errors++;
            end
        end
        rst_n = 1'b1;
        for (int i = 0; i < RST_HOLD; i++) begin
            tick();
            if (req_ready !== 1'b0) begin
                $display("ERR req_ready expected %h got %h", 1'b0, req_ready);
                tb_errors++;
            end
        end
        waited = 0;
        while (req_ready !== 1'b1 && waited < WAIT_CYCLES) begin
            tick();
            waited++;
        end
        if (req_ready !== 1'b1) begin
            $display("timeout: req_ready never rose after reset");
            timeouts++;
        end
    endtask

    task automatic check_full_words();
        for (int i = 0; i < WORDS_USED; i++) begin
            used_addr[i] = addr_t'($random(seed));
            send_req(make_req(1'b1, 4'hf, used_addr[i], data_t'($random(seed))));
        end
        for (int i = 0; i < WORDS_USED; i++) begin
            send_req(make_req(1'b0, 4'h0, used_addr[i], '0));
        end
        wait_drained();
    endtask

    task automatic check_byte_merge();
        for (int i = 0; i < WORDS_USED; i++) begin
            send_req(make_req(1'b1, strb_t'($random(seed)), used_addr[i], data_t'($random(seed))));
            send_req(make_req(1'b0, 4'h0, used_addr[i], '0));
        end
        wait_drained();
    endtask

    task automatic check_order_burst();
        int cycles;
        // bridge idle for a while before the timed request
        repeat (4) tick();
        send_req(make_req(1'b0, 4'h0, used_addr[0], '0));
        cycles = 0;
        while (rsp_valid !== 1'b1 && cycles < WAIT_CYCLES) begin
            tick();
            cycles++;
        end
        if (rsp_valid !== 1'b1) begin
            $display("timeout: no response to the timed request");
            timeouts++;
        end else if (cycles != IDLE_LATENCY) begin
            $display("ERR rsp_valid latency expected %h got %h", IDLE_LATENCY, cycles);
            tb_errors++;
        end
        for (int i = 0; i < BURST_LEN; i++) begin
            send_req(random_req());
        end
        wait_drained();
    endtask

    task automatic check_back_pressure();
        int accepted;
        rsp_mode = READY_LOW;
        tick();
        tick();
        accepted  = 0;
        req_valid = 1'b1;
        req       = random_req();
        while (req_ready === 1'b1 && accepted < BP_LIMIT) begin
            tick();
            accepted++;
            sent++;
            req = random_req();
        end
        if (req_ready === 1'b1) begin
            $display("req_ready never fell while responses were blocked");
            tb_errors++;
        end else if (accepted > FIFO_DEPTH + 1) begin
            $display("ERR accepted requests expected %h got %h", FIFO_DEPTH + 1, accepted);
            tb_errors++;
        end
        // the stalled request is still offered and completes here
        rsp_mode = READY_RANDOM;
        send_req(req);
        for (int i = 0; i < BURST_LEN; i++) begin
            send_req(random_req());
        end
        wait_drained();
        rsp_mode = READY_HIGH;
        if (sb_responses != sent) begin
            $display("ERR response count expected %h got %h", sent, sb_responses);
            tb_errors++;
        end
    endtask

    function automatic string test_name(input int t);
        case (t)
            0:       return "reset hold";
            1:       return "full-word write and read-back";
            2:       return "byte-enable merge";
            3:       return "order and back-to-back traffic";
            default: return "back-pressure";
        endcase
    endfunction

    initial begin
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            if (timeouts == 0) begin
                err_mark     = error_total();
                timeout_mark = timeouts;
                case (t)
                    0:       check_reset_hold();
                    1:       check_full_words();
                    2:       check_byte_merge();
                    3:       check_order_burst();
                    default: check_back_pressure();
                endcase
                if (error_total() == err_mark && timeouts == timeout_mark) begin
                    $display("test %0d %s: ok", t + 1, test_name(t));
                end else begin
                    tests_failed++;
                    $display("test %0d %s: failed with %0d errors", t + 1, test_name(t),
                             error_total() - err_mark);
                end
            end
        end
        $display("summary: %0d tests failed, %0d responses checked, %0d errors, %0d timeouts",
                 tests_failed, sb_responses, error_total(), timeouts);
        if (tests_failed == 0 && error_total() == 0 && timeouts == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
